// ==== verilog.f ====
hdl/obi_pkg.sv
hdl/scan_pkg.sv
hdl/bus_ifs.sv
hdl/obi_port_wrap.sv
hdl/mem_scanner.sv
hdl/obi_ram.sv
hdl/apb_csr.sv
hdl/scrub_top.sv
test/tb_clk_gen.sv
test/scrub_props.sv
test/tb_scrub_top.sv

// ==== Makefile ====
# Verilator build and run of the scrub subsystem testbench
TOP := tb_scrub_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f

# Passes only when the pass line shows up in the simulator output
run: compile
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TB PASSED'

clean:
	rm -rf obj_dir

// ==== test/tb_scrub_top.sv ====
/*
  Testbench for scrub_top. APB inputs change 10 ns after each rising edge.
  A model RAM filled from $urandom (seed 69) gives the expected sums.
  Scan length is timed from irq_o, which lags done by one cycle.
*/

`timescale 1ns/100ps

module tb_scrub_top;
    import obi_pkg::*, scan_pkg::*;

    localparam int DRIVE_DLY      = 10;
    // Loads and readbacks take about 1300 cycles, the scans under 900
    localparam int TIMEOUT_CYCLES = 4000;
    // A full 511-word scan with margin
    localparam int SCAN_LIMIT     = 1100;
    localparam int START_IRQ      = (1 << CTRL_START) | (1 << CTRL_IRQ_EN);

    logic              clk;
    logic              reset;
    logic [CSR_AW-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [DATA_W-1:0] pwdata;
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
    logic              irq;
    logic              alert_major;

    logic [DATA_W-1:0] model [MEM_WORDS];
    int                cycle_cnt = 0;
    int                start_cyc = 0;
    int                checks    = 0;
    int                test_errs = 0;
    int                err_total = 0;
    int                tests_run = 0;

    tb_clk_gen clk_gen (.clk_o(clk), .reset_o(reset));

    scrub_top UUT (
        .clk_i         (clk),
        .reset_i       (reset),
        .paddr_i       (paddr),
        .psel_i        (psel),
        .penable_i     (penable),
        .pwrite_i      (pwrite),
        .pwdata_i      (pwdata),
        .prdata_o      (prdata),
        .pready_o      (pready),
        .pslverr_o     (pslverr),
        .irq_o         (irq),
        .alert_major_o (alert_major)
    );

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("timeout: run stopped after %0d cycles", cycle_cnt);
        $display("TB FAILED");
        $finish;
    end

    // ----------------------------------------
    // Checks and reporting
    // ----------------------------------------

    task automatic check_val(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_cond(input logic ok, input string what);
        checks++;
        assert (ok === 1'b1) else begin
            $display("check failed: %s", what);
            test_errs++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        err_total += test_errs;
        $display("test %0d %s: %s, %0d errors", tests_run, name,
                 (test_errs == 0) ? "ok" : "failing", test_errs);
        test_errs = 0;
    endtask

    // ----------------------------------------
    // APB transfers
    // ----------------------------------------

    // Entered and left 10 ns after a rising edge
    task automatic apb_xfer(input logic wr, input logic [CSR_AW-1:0] addr,
                            input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata,
                            output logic err, output int waits);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #DRIVE_DLY;
        penable = 1'b1;
        waits   = 0;
        // Sample once the new inputs have settled
        #1;
        while (!pready && waits < 4) begin
            waits++;
            @(posedge clk);
            #(DRIVE_DLY + 1);
        end
        check_cond(pready, "APB access never got pready");
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #DRIVE_DLY;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [CSR_AW-1:0] addr, input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] rd;
        logic              err;
        int                waits;
        apb_xfer(1'b1, addr, data, rd, err, waits);
        check_val("pslverr_o", err, 0);
    endtask

    task automatic apb_read(input logic [CSR_AW-1:0] addr, output logic [DATA_W-1:0] data,
                            output int waits);
        logic err;
        apb_xfer(1'b0, addr, '0, data, err, waits);
        check_val("pslverr_o", err, 0);
    endtask

    // ----------------------------------------
    // Scans and reference model
    // ----------------------------------------

    function automatic logic [DATA_W-1:0] expected_sum(input int base, input int count);
        logic [DATA_W-1:0] s;
        s = '0;
        for (int i = 0; i < count; i++) begin
            s += model[(base + i) % MEM_WORDS];
        end
        return s;
    endfunction

    // irq_en cleared first so irq_o cannot be left over from an older scan
    task automatic start_scan(input int base, input int count);
        apb_write(CSR_BASE, base);
        apb_write(CSR_COUNT, count);
        apb_write(CSR_CTRL, 0);
        apb_write(CSR_CTRL, START_IRQ);
        start_cyc = cycle_cnt;
    endtask

    // Cycle of done, counted from the start write as cycle 0
    task automatic wait_scan(output int done_cyc);
        while (!irq && cycle_cnt - start_cyc < SCAN_LIMIT) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        check_cond(irq, "scan did not finish");
        done_cyc = cycle_cnt - start_cyc;
    endtask

    task automatic scan_and_check(input int base, input int count);
        logic [DATA_W-1:0] rd;
        int                waits;
        int                cyc;
        start_scan(base, count);
        wait_scan(cyc);
        check_val("done cycles", cyc, 2 * count + 1);
        apb_read(CSR_STATUS, rd, waits);
        check_val("STATUS", rd, 1 << ST_DONE);
        apb_read(CSR_SUM, rd, waits);
        check_val("SUM", rd, expected_sum(base, count));
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    initial begin
        logic [DATA_W-1:0] rd;
        logic              err;
        int                waits;
        int                cyc;
        int                word;
        int                prop_fails;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        void'($urandom(69));
        for (int i = 0; i < MEM_WORDS; i++) begin
            model[i] = $urandom();
        end
        @(negedge reset);
        @(posedge clk);
        #DRIVE_DLY;

        // Register widths and the error response
        apb_write(CSR_BASE, 32'h0000_0FBC);
        apb_read(CSR_BASE, rd, waits);
        check_val("BASE", rd, 32'h0000_00BC);
        apb_write(CSR_COUNT, 32'hFFFF_FF37);
        apb_read(CSR_COUNT, rd, waits);
        check_val("COUNT", rd, 32'h0000_0137);
        apb_xfer(1'b0, 8'h1C, '0, rd, err, waits);
        check_val("pslverr_o", err, 1);
        apb_xfer(1'b1, 8'h40, 32'h1, rd, err, waits);
        check_val("pslverr_o", err, 1);
        finish_test("registers");

        // Full RAM load and readback, one wait state per read
        apb_write(CSR_MEM_ADDR, 0);
        for (int i = 0; i < MEM_WORDS; i++) begin
            apb_write(CSR_MEM_DATA, model[i]);
        end
        apb_write(CSR_MEM_ADDR, 0);
        for (int i = 0; i < MEM_WORDS; i++) begin
            apb_read(CSR_MEM_DATA, rd, waits);
            check_val("MEM_DATA", rd, model[i]);
            check_val("MEM_DATA wait states", waits, 1);
        end
        // Index wraps after a full pass
        apb_read(CSR_MEM_ADDR, rd, waits);
        check_val("MEM_ADDR", rd, 0);
        finish_test("ram load");

        scan_and_check($urandom() % MEM_WORDS, 1 + $urandom() % 64);
        scan_and_check(7, 0);
        finish_test("scan sum");

        // Top six words, then six from index 0
        scan_and_check(MEM_WORDS - 6, 12);
        finish_test("wrap-around");

        apb_write(CSR_CTRL, 1 << CTRL_INJECT);
        start_scan(16, 8);
        wait_scan(cyc);
        check_val("alert_major_o", alert_major, 1);
        apb_read(CSR_STATUS, rd, waits);
        check_val("STATUS", rd, (1 << ST_DONE) | (1 << ST_ALERT));
        // Fault on the first grant, so nothing was added
        apb_read(CSR_SUM, rd, waits);
        check_val("SUM", rd, 0);
        scan_and_check(16, 8);
        check_val("alert_major_o", alert_major, 0);
        finish_test("fault injection");

        word = 64;
        start_scan(48, 100);
        apb_write(CSR_MEM_ADDR, word);
        apb_write(CSR_MEM_DATA, ~model[word]);
        apb_write(CSR_CTRL, START_IRQ);
        wait_scan(cyc);
        check_val("done cycles", cyc, 2 * 100 + 1);
        apb_read(CSR_SUM, rd, waits);
        check_val("SUM", rd, expected_sum(48, 100));
        apb_write(CSR_MEM_ADDR, word);
        apb_read(CSR_MEM_DATA, rd, waits);
        check_val("MEM_DATA", rd, model[word]);
        finish_test("busy lockout");

        prop_fails = UUT.u_props.fail_cnt;
        err_total += prop_fails;
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests_run, checks, err_total, prop_fails);
        if (err_total == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule : tb_scrub_top

// ==== test/scrub_props.sv ====
/*
  Concurrent checks bound into scrub_top.
  Covers the OBI request and response handshake, APB wait states
  and the values of the control outputs right after reset.
*/

`timescale 1ns/100ps

module scrub_props
    import obi_pkg::*;
(
    input logic              clk_i,
    input logic              reset_i,
    input logic              obi_req_i,
    input logic              obi_gnt_i,
    input logic [ADDR_W-1:0] obi_addr_i,
    input logic              obi_rvalid_i,
    input logic              psel_i,
    input logic              penable_i,
    input logic              pready_i,
    input logic              pslverr_i,
    input logic              irq_i,
    input logic              alert_major_i,
    input logic              busy_i,
    input logic              done_i
);

    // Number of failed checks
    int unsigned fail_cnt = 0;

    // ----------------------------------------
    // OBI handshake
    // ----------------------------------------

    // Request held, address unchanged, until the grant
    req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        obi_req_i && !obi_gnt_i |=> obi_req_i && $stable(obi_addr_i))
        else begin
            $error("OBI request dropped or changed before its grant");
            fail_cnt++;
        end

    // rvalid exactly one cycle after each grant, never otherwise
    rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (reset_i)
        obi_rvalid_i == $past(obi_req_i && obi_gnt_i))
        else begin
            $error("OBI rvalid not one cycle after a grant");
            fail_cnt++;
        end

    // ----------------------------------------
    // APB and reset
    // ----------------------------------------

    // At most one wait state, so pready comes within two cycles of setup
    pready_in_time: assert property (@(posedge clk_i) disable iff (reset_i)
        psel_i && penable_i && !pready_i |=> pready_i)
        else begin
            $error("APB access waited more than one cycle for pready");
            fail_cnt++;
        end

    reset_values: assert property (@(posedge clk_i)
        reset_i |=> !obi_req_i && !pready_i && !pslverr_i && !irq_i
                    && !alert_major_i && !busy_i && !done_i)
        else begin
            $error("Control output high right after reset");
            fail_cnt++;
        end

endmodule : scrub_props

bind scrub_top scrub_props u_props (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .obi_req_i     (obi_bus.req),
    .obi_gnt_i     (obi_bus.gnt),
    .obi_addr_i    (obi_bus.addr),
    .obi_rvalid_i  (obi_bus.rvalid),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pready_i      (pready_o),
    .pslverr_i     (pslverr_o),
    .irq_i         (irq_o),
    .alert_major_i (alert_major_o),
    .busy_i        (busy),
    .done_i        (done)
);

// ==== test/tb_clk_gen.sv ====
/*
  Free-running 100 ns clock, first rising edge at 50 ns.
  Reset is held high over the first two rising edges.
*/

`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk_o,
    output logic reset_o
);

    localparam int HALF_PERIOD = 50;
    // Release lands on the same offset as the stimulus
    localparam int RELEASE_DLY = 10;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (2) @(posedge clk_o);
        #RELEASE_DLY;
        reset_o = 1'b0;
    end

endmodule : tb_clk_gen

// ==== hdl/scrub_top.sv ====
/*
  Memory scrub subsystem top. APB control, one OBI read path from the
  scanner to the RAM, interrupt on scan completion and a major alert
  on any bus parity fault. Single clock, synchronous reset.
*/

`timescale 1ns/100ps

module scrub_top
    import obi_pkg::*, scan_pkg::*;
(
    input  logic              clk_i,
    input  logic              reset_i,
    // APB slave
    input  logic [CSR_AW-1:0] paddr_i,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  logic [DATA_W-1:0] pwdata_i,
    output logic [DATA_W-1:0] prdata_o,
    output logic              pready_o,
    output logic              pslverr_o,
    // Events
    output logic              irq_o,
    output logic              alert_major_o
);

    // Scanner control
    logic               start;
    logic [MEM_AW-1:0]  base;
    logic [COUNT_W-1:0] count;
    logic               busy;
    logic               done;
    logic [DATA_W-1:0]  sum;
    logic               alert;
    // RAM load port and fault injection
    logic               inject;
    logic               ld_we;
    logic [MEM_AW-1:0]  ld_addr;
    logic [DATA_W-1:0]  ld_wdata;
    logic [DATA_W-1:0]  ld_rdata;

    core_bus_if core_bus (.clk_i(clk_i), .reset_i(reset_i));
    obi_bus_if  obi_bus  (.clk_i(clk_i), .reset_i(reset_i));

    // ----------------------------------------
    // Read path
    // ----------------------------------------

    mem_scanner u_scanner (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .bus     (core_bus.requester),
        .start_i (start),
        .base_i  (base),
        .count_i (count),
        .alert_i (alert),
        .busy_o  (busy),
        .done_o  (done),
        .sum_o   (sum)
    );

    obi_port_wrap u_port_wrap (
        .core    (core_bus.adapter),
        .obi     (obi_bus.manager),
        .alert_o (alert)
    );

    obi_ram u_ram (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .obi        (obi_bus.subordinate),
        .inject_i   (inject),
        .ld_we_i    (ld_we),
        .ld_addr_i  (ld_addr),
        .ld_wdata_i (ld_wdata),
        .ld_rdata_o (ld_rdata)
    );

    // ----------------------------------------
    // Register block
    // ----------------------------------------

    apb_csr u_csr (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .paddr_i       (paddr_i),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .pwdata_i      (pwdata_i),
        .prdata_o      (prdata_o),
        .pready_o      (pready_o),
        .pslverr_o     (pslverr_o),
        .start_o       (start),
        .base_o        (base),
        .count_o       (count),
        .busy_i        (busy),
        .done_i        (done),
        .sum_i         (sum),
        .alert_i       (alert),
        .inject_o      (inject),
        .irq_o         (irq_o),
        .alert_major_o (alert_major_o),
        .ld_we_o       (ld_we),
        .ld_addr_o     (ld_addr),
        .ld_wdata_o    (ld_wdata),
        .ld_rdata_i    (ld_rdata)
    );

endmodule : scrub_top

// ==== hdl/apb_csr.sv ====
/*
  APB slave with the control, status and RAM access registers.
  Register accesses finish in the first access cycle; a MEM_DATA read
  takes one wait state. Unmapped offsets return pslverr.
  RAM loads and starts are dropped while a scan is busy.
*/

`timescale 1ns/100ps

module apb_csr
    import obi_pkg::*, scan_pkg::*;
(
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic [CSR_AW-1:0]  paddr_i,
    input  logic               psel_i,
    input  logic               penable_i,
    input  logic               pwrite_i,
    input  logic [DATA_W-1:0]  pwdata_i,
    output logic [DATA_W-1:0]  prdata_o,
    output logic               pready_o,
    output logic               pslverr_o,
    output logic               start_o,
    output logic [MEM_AW-1:0]  base_o,
    output logic [COUNT_W-1:0] count_o,
    input  logic               busy_i,
    input  logic               done_i,
    input  logic [DATA_W-1:0]  sum_i,
    input  logic               alert_i,
    output logic               inject_o,
    output logic               irq_o,
    output logic               alert_major_o,
    output logic               ld_we_o,
    output logic [MEM_AW-1:0]  ld_addr_o,
    output logic [DATA_W-1:0]  ld_wdata_o,
    input  logic [DATA_W-1:0]  ld_rdata_i
);

    logic               irq_en_q;
    logic               inject_q;
    logic [MEM_AW-1:0]  base_q;
    logic [COUNT_W-1:0] count_q;
    logic [MEM_AW-1:0]  mem_addr_q;
    logic               alert_q;
    logic               rd_wait_q;
    logic               access;
    logic               mapped;
    logic               mem_rd;
    logic               wr_done;
    logic               rd_done;

    // ----------------------------------------
    // Decode and handshake
    // ----------------------------------------

    assign access = psel_i & penable_i;
    assign mem_rd = access & ~pwrite_i & (paddr_i == CSR_MEM_DATA);

    // Read mux and offset check
    always_comb begin
        mapped   = 1'b1;
        prdata_o = '0;
        case (paddr_i)
            CSR_CTRL: begin
                prdata_o[CTRL_IRQ_EN] = irq_en_q;
                prdata_o[CTRL_INJECT] = inject_q;
            end
            CSR_BASE:     prdata_o[MEM_AW-1:0]  = base_q;
            CSR_COUNT:    prdata_o[COUNT_W-1:0] = count_q;
            CSR_STATUS: begin
                prdata_o[ST_BUSY]  = busy_i;
                prdata_o[ST_DONE]  = done_i;
                prdata_o[ST_ALERT] = alert_major_o;
            end
            CSR_SUM:      prdata_o = sum_i;
            CSR_MEM_ADDR: prdata_o[MEM_AW-1:0]  = mem_addr_q;
            CSR_MEM_DATA: prdata_o = ld_rdata_i;
            default:      mapped = 1'b0;
        endcase
    end

    // MEM_DATA read waits one cycle for the RAM read port
    assign pready_o  = access & (~mem_rd | rd_wait_q);
    assign pslverr_o = pready_o & ~mapped;
    assign wr_done   = pready_o & mapped & pwrite_i;
    assign rd_done   = pready_o & mapped & ~pwrite_i;

    // ----------------------------------------
    // Scanner and RAM side
    // ----------------------------------------

    assign start_o = wr_done & (paddr_i == CSR_CTRL) & pwdata_i[CTRL_START] & ~busy_i;
    assign ld_we_o = wr_done & (paddr_i == CSR_MEM_DATA) & ~busy_i;

    assign base_o     = base_q;
    assign count_o    = count_q;
    assign inject_o   = inject_q;
    assign ld_addr_o  = mem_addr_q;
    assign ld_wdata_o = pwdata_i;

    // Raised the cycle after a mismatch, then held by the sticky bit
    assign alert_major_o = alert_q | alert_i;

    // ----------------------------------------
    // Registers
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            irq_en_q   <= 1'b0;
            inject_q   <= 1'b0;
            base_q     <= '0;
            count_q    <= '0;
            mem_addr_q <= '0;
            alert_q    <= 1'b0;
            rd_wait_q  <= 1'b0;
            irq_o      <= 1'b0;
        end else begin
            rd_wait_q <= mem_rd & ~pready_o;
            irq_o     <= done_i & irq_en_q;
            // Inject is a one-cycle pulse, consumed by the RAM arm flag
            inject_q  <= 1'b0;
            if (wr_done) begin
                case (paddr_i)
                    CSR_CTRL: begin
                        irq_en_q <= pwdata_i[CTRL_IRQ_EN];
                        inject_q <= pwdata_i[CTRL_INJECT];
                    end
                    CSR_BASE:     base_q     <= pwdata_i[MEM_AW-1:0];
                    CSR_COUNT:    count_q    <= pwdata_i[COUNT_W-1:0];
                    CSR_MEM_ADDR: mem_addr_q <= pwdata_i[MEM_AW-1:0];
                    default: ;
                endcase
            end
            // Auto-increment after each data access
            if (ld_we_o || (rd_done && paddr_i == CSR_MEM_DATA)) begin
                mem_addr_q <= mem_addr_q + 1'b1;
            end
            // Sticky alert, set wins over the clearing start
            if (alert_i) begin
                alert_q <= 1'b1;
            end else if (start_o) begin
                alert_q <= 1'b0;
            end
        end
    end

endmodule : apb_csr

// ==== hdl/obi_ram.sv ====
/*
  Single-port word RAM with an OBI read responder and an APB load port.
  Grants every request in its own cycle, rvalid one cycle later.
  Both read ports are synchronous. An armed injection flips gntpar on
  the next grant only.
*/

`timescale 1ns/100ps

module obi_ram
    import obi_pkg::*;
(
    input  logic                clk_i,
    input  logic                reset_i,
    obi_bus_if.subordinate      obi,
    input  logic                inject_i,
    input  logic                ld_we_i,
    input  logic [MEM_AW-1:0]   ld_addr_i,
    input  logic [DATA_W-1:0]   ld_wdata_i,
    output logic [DATA_W-1:0]   ld_rdata_o
);

    logic [DATA_W-1:0] mem_q [MEM_WORDS];
    logic [DATA_W-1:0] rdata_q;
    logic [DATA_W-1:0] lane_mask;
    logic [MEM_AW-1:0] rd_idx;
    logic              rvalid_q;
    logic              inj_armed_q;

    // Word index from the byte address, upper bits ignored
    assign rd_idx = obi.addr[MEM_AW+WORD_LSB-1:WORD_LSB];

    // Byte enables to lane mask
    always_comb begin
        for (int b = 0; b < BE_W; b++) begin
            lane_mask[8*b +: 8] = {8{obi.be[b]}};
        end
    end

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (ld_we_i) begin
            mem_q[ld_addr_i] <= ld_wdata_i;
        end
        // Load port reads every cycle
        ld_rdata_o <= mem_q[ld_addr_i];
        // OBI read data captured on a granted read
        if (obi.req && obi.gnt && !obi.we) begin
            rdata_q <= mem_q[rd_idx] & lane_mask;
        end
    end

    // ----------------------------------------
    // Handshake and fault injection
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rvalid_q    <= 1'b0;
            inj_armed_q <= 1'b0;
        end else begin
            rvalid_q    <= obi.req & obi.gnt;
            // Consumed by a grant, re-armed by a new pulse
            inj_armed_q <= inject_i | (inj_armed_q & ~obi.gnt);
        end
    end

    assign obi.gnt = obi.req;
    // Corrupt only a granting cycle so an idle armed RAM stays clean
    assign obi.gntpar    = ~obi.gnt ^ (inj_armed_q & obi.gnt);
    assign obi.rvalid    = rvalid_q;
    assign obi.rvalidpar = ~rvalid_q;
    assign obi.rdata     = rdata_q;

endmodule : obi_ram

// ==== hdl/mem_scanner.sv ====
/*
  Reads count words from consecutive RAM indices starting at base and
  adds them into a 32-bit wrap-around sum. Two cycles per word.
  The index wraps modulo the RAM depth. An alert aborts the scan.
*/

`timescale 1ns/100ps

module mem_scanner
    import obi_pkg::*, scan_pkg::*;
(
    input  logic               clk_i,
    input  logic               reset_i,
    core_bus_if.requester      bus,
    input  logic               start_i,
    input  logic [MEM_AW-1:0]  base_i,
    input  logic [COUNT_W-1:0] count_i,
    input  logic               alert_i,
    output logic               busy_o,
    output logic               done_o,
    output logic [DATA_W-1:0]  sum_o
);

    scan_state_e        state_q;
    logic [MEM_AW-1:0]  idx_q;
    // Words still to be requested
    logic [COUNT_W-1:0] left_q;
    logic [DATA_W-1:0]  sum_q;

    // ----------------------------------------
    // Scan FSM
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= SCAN_IDLE;
            idx_q   <= '0;
            left_q  <= '0;
            sum_q   <= '0;
        end else begin
            case (state_q)
                SCAN_IDLE, SCAN_DONE: begin
                    if (start_i) begin
                        idx_q   <= base_i;
                        left_q  <= count_i;
                        sum_q   <= '0;
                        // Empty window finishes at once
                        state_q <= (count_i == '0) ? SCAN_DONE : SCAN_REQ;
                    end
                end
                SCAN_REQ: begin
                    if (alert_i) begin
                        state_q <= SCAN_DONE;
                    end else if (bus.gnt) begin
                        idx_q   <= idx_q + 1'b1;
                        left_q  <= left_q - 1'b1;
                        state_q <= SCAN_WAIT;
                    end
                end
                SCAN_WAIT: begin
                    // Partial sum is kept when aborted
                    if (alert_i) begin
                        state_q <= SCAN_DONE;
                    end else if (bus.rvalid) begin
                        sum_q   <= sum_q + bus.rdata;
                        state_q <= (left_q == '0) ? SCAN_DONE : SCAN_REQ;
                    end
                end
                default: state_q <= SCAN_IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // Outputs
    // ----------------------------------------

    // req held for the whole REQ state, so it is stable until granted
    assign bus.req  = (state_q == SCAN_REQ);
    // Word index to byte address
    assign bus.addr = {{(ADDR_W-MEM_AW-WORD_LSB){1'b0}}, idx_q, {WORD_LSB{1'b0}}};

    assign busy_o = (state_q == SCAN_REQ) || (state_q == SCAN_WAIT);
    assign done_o = (state_q == SCAN_DONE);
    assign sum_o  = sum_q;

endmodule : mem_scanner

// ==== hdl/obi_port_wrap.sv ====
/*
  Adapts the plain requester bus to the OBI subset.
  Read-only port: we is tied low and be to a full word.
  Parity is inverted polarity. A mismatch shows on alert_o one cycle
  later as a level per cycle; the sticky copy lives in the CSR block.
*/

`timescale 1ns/100ps

module obi_port_wrap
    import obi_pkg::*;
(
    core_bus_if.adapter core,
    obi_bus_if.manager  obi,
    output logic        alert_o
);

    logic gnt_par_err;
    logic rvalid_par_err;

    // ----------------------------------------
    // Request side
    // ----------------------------------------

    // Address phase passes straight through
    assign obi.req  = core.req;
    assign obi.addr = core.addr;

    // Fixed fields of a read-only manager
    assign obi.we = 1'b0;
    assign obi.be = {BE_W{1'b1}};

    // Inverted parity on req
    assign obi.reqpar = ~core.req;

    // ----------------------------------------
    // Response side
    // ----------------------------------------

    assign core.gnt    = obi.gnt;
    assign core.rvalid = obi.rvalid;
    assign core.rdata  = obi.rdata;

    // ----------------------------------------
    // Parity check
    // ----------------------------------------

    // A parity bit equal to its signal is a fault, checked every cycle
    // whether or not a transfer is in flight
    assign gnt_par_err    = (obi.gntpar == obi.gnt);
    assign rvalid_par_err = (obi.rvalidpar == obi.rvalid);

    always_ff @(posedge obi.clk_i) begin
        if (obi.reset_i) begin
            alert_o <= 1'b0;
        end else begin
            // Flagged for one cycle per faulty cycle
            alert_o <= gnt_par_err | rvalid_par_err;
        end
    end

endmodule : obi_port_wrap

// ==== hdl/bus_ifs.sv ====
/*
  Internal bus interfaces of the scrub subsystem.
  core_bus_if is the plain requester side, obi_bus_if the OBI 1.2 subset
  with parity on req, gnt and rvalid. One transaction outstanding at most.
*/

`timescale 1ns/100ps

// Simple requester bus between the scanner and the OBI adapter
interface core_bus_if
    import obi_pkg::*;
(
    input logic clk_i,
    input logic reset_i
);
    logic              req;
    logic [ADDR_W-1:0] addr;
    logic              gnt;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;

    modport requester (
        input  clk_i, reset_i,
        output req, addr,
        input  gnt, rvalid, rdata
    );

    modport adapter (
        input  clk_i, reset_i,
        input  req, addr,
        output gnt, rvalid, rdata
    );
endinterface : core_bus_if

// OBI subset between the adapter and the RAM
interface obi_bus_if
    import obi_pkg::*;
(
    input logic clk_i,
    input logic reset_i
);
    // Request channel
    logic              req;
    logic              reqpar;
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [BE_W-1:0]   be;
    logic              gnt;
    logic              gntpar;
    // Response channel
    logic              rvalid;
    logic              rvalidpar;
    logic [DATA_W-1:0] rdata;

    modport manager (
        input  clk_i, reset_i,
        output req, reqpar, addr, we, be,
        input  gnt, gntpar, rvalid, rvalidpar, rdata
    );

    modport subordinate (
        input  clk_i, reset_i,
        input  req, reqpar, addr, we, be,
        output gnt, gntpar, rvalid, rvalidpar, rdata
    );
endinterface : obi_bus_if

// ==== hdl/scan_pkg.sv ====
/*
  APB register map and scanner state encoding.
  Register offsets are byte offsets on an 8-bit APB address.
  Unlisted offsets answer with an error response.
*/

package scan_pkg;

    localparam int CSR_AW  = 8;
    // Word count is one bit wider than the RAM index so a full pass fits
    localparam int COUNT_W = 9;

    // CTRL bit positions
    localparam int CTRL_START  = 0;
    localparam int CTRL_IRQ_EN = 1;
    localparam int CTRL_INJECT = 2;

    // STATUS bit positions
    localparam int ST_BUSY  = 0;
    localparam int ST_DONE  = 1;
    localparam int ST_ALERT = 2;

    typedef enum logic [CSR_AW-1:0] {
        CSR_CTRL     = 8'h00,
        CSR_BASE     = 8'h04,
        CSR_COUNT    = 8'h08,
        CSR_STATUS   = 8'h0C,
        CSR_SUM      = 8'h10,
        CSR_MEM_ADDR = 8'h14,
        CSR_MEM_DATA = 8'h18
    } csr_addr_e;

    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_REQ,
        SCAN_WAIT,
        SCAN_DONE
    } scan_state_e;

endpackage : scan_pkg

// ==== hdl/obi_pkg.sv ====
/*
  OBI bus widths and on-chip RAM geometry.
  Addresses are byte addresses; the RAM decodes word index bits only,
  so any address wraps modulo the RAM size.
*/

package obi_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W   = DATA_W / 8;

    // RAM geometry
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = $clog2(MEM_WORDS);

    // Low address bits that select a byte inside a word
    localparam int WORD_LSB  = 2;

endpackage : obi_pkg
